// File: hdc_params.svh
`ifndef HDC_PARAMS_SVH
`define HDC_PARAMS_SVH

// vector geometry
`define HDC_DIM          256
`define HDC_WORD         32
`define HDC_NVEC         4
`define HDC_WPV          8
`define HDC_SHIFT_W      8
// index widths for vector and word selects
`define HDC_VSEL_W       2
`define HDC_WSEL_W       3

// register map, byte addresses
`define HDC_ADR_W        12
`define HDC_ADR_CMD      12'h000
`define HDC_ADR_STATUS   12'h004
`define HDC_ADR_VEC_BASE 12'h100

// command word fields, lsb positions
`define HDC_CMD_START    0
`define HDC_CMD_OP       1
`define HDC_CMD_SRC_A    4
`define HDC_CMD_SRC_B    6
`define HDC_CMD_DST      8
`define HDC_CMD_SHIFT    16

`endif

// File: hdc_pkg.sv
package hdc_pkg;

    // operation codes, as written to cmd bits 2:1
    typedef enum logic [1:0] {
        OP_NOP          = 2'd0,
        OP_PERMUTE      = 2'd1,
        OP_BIND         = 2'd2,
        OP_PERMUTE_BIND = 2'd3
    } hdc_op_e;

    // engine sequencer states
    typedef enum logic [1:0] {
        // waiting for start
        S_IDLE  = 2'd0,
        // rotator pipeline advancing
        S_RUN   = 2'd1,
        // result written back to bank
        S_WRITE = 2'd2
    } eng_state_e;

endpackage

// File: hdc_permute.sv
`timescale 1ns/1ps

module hdc_permute #(
    parameter int DIM_W = 256
) (
    input  logic                       clk,
    input  logic                       exec,
    input  logic [DIM_W-1:0]           data,
    input  logic [$clog2(DIM_W)-1:0]   shift,
    output logic [DIM_W-1:0]           result
);

    // one stage per shift bit
    localparam int NSTG = $clog2(DIM_W);

    genvar s;
    generate
        for (s = 0; s < NSTG; s++) begin : g_stage
            // rotate amount of this stage
            localparam int AMT = 1 << s;
            // stage output register
            logic [DIM_W-1:0] q;

            if (s == 0) begin : g_rot
                // first stage reads the ports directly
                always_ff @(posedge clk) begin
                    if (exec) begin
                        if (shift[0]) begin
                            q <= {data[0], data[DIM_W-1:1]};
                        end else begin
                            q <= data;
                        end
                    end
                end
            end else begin : g_rot
                // shift bits s and up, delayed to line up with d_prev
                logic [NSTG-1-s:0] sh;
                logic [DIM_W-1:0]  d_prev;

                assign d_prev = g_stage[s-1].q;

                if (s == 1) begin : g_sh
                    always_ff @(posedge clk) begin
                        if (exec) begin
                            sh <= shift[NSTG-1:1];
                        end
                    end
                end else begin : g_sh
                    // drop the bit consumed by the previous stage
                    always_ff @(posedge clk) begin
                        if (exec) begin
                            sh <= g_stage[s-1].g_rot.sh[NSTG-s:1];
                        end
                    end
                end

                // rotate toward bit 0 by 2^s
                always_ff @(posedge clk) begin
                    if (exec) begin
                        if (sh[0]) begin
                            q <= {d_prev[AMT-1:0], d_prev[DIM_W-1:AMT]};
                        end else begin
                            q <= d_prev;
                        end
                    end
                end
            end
        end
    endgenerate

    // last stage holds the fully rotated vector
    assign result = g_stage[NSTG-1].q;

endmodule

// File: hdc_vector_bank.sv
`timescale 1ns/1ps
`include "hdc_params.svh"

module hdc_vector_bank (
    input  logic                     clk,
    input  logic                     rst_n,
    // word write from bus side
    input  logic                     wr_en,
    input  logic [`HDC_VSEL_W-1:0]   wr_vec,
    input  logic [`HDC_WSEL_W-1:0]   wr_word,
    input  logic [`HDC_WORD-1:0]     wr_data,
    // word read
    input  logic [`HDC_VSEL_W-1:0]   rd_vec,
    input  logic [`HDC_WSEL_W-1:0]   rd_word,
    output logic [`HDC_WORD-1:0]     rd_data,
    // full-vector reads for the engine
    input  logic [`HDC_VSEL_W-1:0]   sel_a,
    input  logic [`HDC_VSEL_W-1:0]   sel_b,
    output logic [`HDC_DIM-1:0]      vec_a,
    output logic [`HDC_DIM-1:0]      vec_b,
    // full-vector result write
    input  logic                     res_en,
    input  logic [`HDC_VSEL_W-1:0]   res_vec,
    input  logic [`HDC_DIM-1:0]      res_data
);

    // the four hypervectors
    logic [`HDC_DIM-1:0] mem [`HDC_NVEC];

    // ------------------------------
    // write side
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int v = 0; v < `HDC_NVEC; v++) begin
                mem[v] <= '0;
            end
        end else if (res_en) begin
            // engine result wins over a word write
            mem[res_vec] <= res_data;
        end else if (wr_en) begin
            // word 0 is bits 31:0
            mem[wr_vec][wr_word * `HDC_WORD +: `HDC_WORD] <= wr_data;
        end
    end

    // ------------------------------
    // read side
    // ------------------------------
    // word mux for bus reads
    assign rd_data = mem[rd_vec][rd_word * `HDC_WORD +: `HDC_WORD];

    // operand ports
    assign vec_a = mem[sel_a];
    assign vec_b = mem[sel_b];

endmodule

// File: hdc_engine.sv
`timescale 1ns/1ps
`include "hdc_params.svh"

module hdc_engine (
    input  logic                     clk,
    input  logic                     rst_n,
    // command from register block
    input  logic                     start,
    input  hdc_pkg::hdc_op_e         op,
    input  logic [`HDC_VSEL_W-1:0]   src_a,
    input  logic [`HDC_VSEL_W-1:0]   src_b,
    input  logic [`HDC_VSEL_W-1:0]   dst,
    input  logic [`HDC_SHIFT_W-1:0]  shift,
    output logic                     busy,
    // operand reads from bank
    output logic [`HDC_VSEL_W-1:0]   sel_a,
    output logic [`HDC_VSEL_W-1:0]   sel_b,
    input  logic [`HDC_DIM-1:0]      vec_a,
    input  logic [`HDC_DIM-1:0]      vec_b,
    // result write to bank
    output logic                     res_en,
    output logic [`HDC_VSEL_W-1:0]   res_vec,
    output logic [`HDC_DIM-1:0]      res_data
);

    // counts the rotator stages, one per shift bit
    localparam int CNT_W = $clog2(`HDC_SHIFT_W);

    hdc_pkg::eng_state_e          state;
    hdc_pkg::hdc_op_e             op_q;
    logic [`HDC_VSEL_W-1:0]       src_a_q;
    logic [`HDC_VSEL_W-1:0]       src_b_q;
    logic [`HDC_VSEL_W-1:0]       dst_q;
    logic [`HDC_SHIFT_W-1:0]      shift_q;
    logic [CNT_W-1:0]             cnt;
    logic                         exec;
    logic                         do_rot;
    logic                         do_bind;
    logic [`HDC_SHIFT_W-1:0]      rot_shift;
    logic [`HDC_DIM-1:0]          rot_res;

    // op decode from the latched command
    assign do_rot  = (op_q == hdc_pkg::OP_PERMUTE) || (op_q == hdc_pkg::OP_PERMUTE_BIND);
    assign do_bind = (op_q == hdc_pkg::OP_BIND) || (op_q == hdc_pkg::OP_PERMUTE_BIND);
    // bind and nop still go through the rotator, unrotated
    assign rot_shift = do_rot ? shift_q : '0;

    // pipeline enable, doubles as stall control
    assign exec = (state == hdc_pkg::S_RUN);
    assign busy = (state != hdc_pkg::S_IDLE);

    hdc_permute #(
        .DIM_W (`HDC_DIM)
    ) u_permute (
        .clk    (clk),
        .exec   (exec),
        .data   (vec_a),
        .shift  (rot_shift),
        .result (rot_res)
    );

    // ------------------------------
    // sequencer
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= hdc_pkg::S_IDLE;
            cnt     <= '0;
            op_q    <= hdc_pkg::OP_NOP;
            src_a_q <= '0;
            src_b_q <= '0;
            dst_q   <= '0;
            shift_q <= '0;
        end else begin
            case (state)
                hdc_pkg::S_IDLE: begin
                    // a start while busy never gets here
                    if (start) begin
                        op_q    <= op;
                        src_a_q <= src_a;
                        src_b_q <= src_b;
                        dst_q   <= dst;
                        shift_q <= shift;
                        cnt     <= '0;
                        state   <= hdc_pkg::S_RUN;
                    end
                end
                hdc_pkg::S_RUN: begin
                    cnt <= cnt + 1'b1;
                    // last stage loaded on this edge
                    if (cnt == CNT_W'(`HDC_SHIFT_W - 1)) begin
                        state <= hdc_pkg::S_WRITE;
                    end
                end
                hdc_pkg::S_WRITE: begin
                    state <= hdc_pkg::S_IDLE;
                end
                default: begin
                    state <= hdc_pkg::S_IDLE;
                end
            endcase
        end
    end

    // ------------------------------
    // operand select and writeback
    // ------------------------------
    assign sel_a    = src_a_q;
    assign sel_b    = src_b_q;
    assign res_vec  = dst_q;
    // nop runs the full path but writes nothing
    assign res_en   = (state == hdc_pkg::S_WRITE) && (op_q != hdc_pkg::OP_NOP);
    assign res_data = do_bind ? (rot_res ^ vec_b) : rot_res;

endmodule

// File: hdc_wb_regs.sv
`timescale 1ns/1ps
`include "hdc_params.svh"

module hdc_wb_regs (
    input  logic                     clk,
    input  logic                     rst_n,
    // wishbone classic slave
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  logic [`HDC_ADR_W-1:0]    wb_adr,
    input  logic [`HDC_WORD-1:0]     wb_dat_w,
    output logic [`HDC_WORD-1:0]     wb_dat_r,
    output logic                     wb_ack,
    // engine command and status
    input  logic                     busy,
    output logic                     start,
    output hdc_pkg::hdc_op_e         op,
    output logic [`HDC_VSEL_W-1:0]   src_a,
    output logic [`HDC_VSEL_W-1:0]   src_b,
    output logic [`HDC_VSEL_W-1:0]   dst,
    output logic [`HDC_SHIFT_W-1:0]  shift,
    // bank word port
    output logic                     wr_en,
    output logic [`HDC_VSEL_W-1:0]   wr_vec,
    output logic [`HDC_WSEL_W-1:0]   wr_word,
    output logic [`HDC_WORD-1:0]     wr_data,
    output logic [`HDC_VSEL_W-1:0]   rd_vec,
    output logic [`HDC_WSEL_W-1:0]   rd_word,
    input  logic [`HDC_WORD-1:0]     rd_data
);

    // bytes covered by the vector window
    localparam int VEC_SPAN = `HDC_NVEC * `HDC_WPV * 4;

    logic                     wait_idle;
    logic                     req;
    logic                     is_cmd;
    logic                     is_status;
    logic                     is_vec;
    logic [`HDC_ADR_W-1:0]    vec_off;
    logic [`HDC_WORD-1:0]     cmd_rd;
    logic [`HDC_WORD-1:0]     rdata;

    // ------------------------------
    // handshake
    // ------------------------------
    // new request only after stb has dropped since the last ack
    assign req = wb_cyc && wb_stb && !wb_ack && !wait_idle;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack    <= 1'b0;
            wait_idle <= 1'b0;
        end else begin
            wb_ack <= req;
            if (req) begin
                wait_idle <= 1'b1;
            end else if (!wb_stb) begin
                wait_idle <= 1'b0;
            end
        end
    end

    // ------------------------------
    // address decode
    // ------------------------------
    assign vec_off   = wb_adr - `HDC_ADR_VEC_BASE;
    assign is_cmd    = (wb_adr == `HDC_ADR_CMD);
    assign is_status = (wb_adr == `HDC_ADR_STATUS);
    assign is_vec    = (wb_adr >= `HDC_ADR_VEC_BASE) && (vec_off < VEC_SPAN);

    // vector v at +v*0x20, word w at +w*4
    assign rd_vec  = vec_off[2 + `HDC_WSEL_W +: `HDC_VSEL_W];
    assign rd_word = vec_off[2 +: `HDC_WSEL_W];
    assign wr_vec  = rd_vec;
    assign wr_word = rd_word;
    assign wr_data = wb_dat_w;
    // bank is frozen while the engine runs, write still acked
    assign wr_en   = req && wb_we && is_vec && !busy;

    // ------------------------------
    // command register
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            start <= 1'b0;
            op    <= hdc_pkg::OP_NOP;
            src_a <= '0;
            src_b <= '0;
            dst   <= '0;
            shift <= '0;
        end else begin
            // one-cycle pulse, engine drops it when busy
            start <= req && wb_we && is_cmd && wb_dat_w[`HDC_CMD_START];
            if (req && wb_we && is_cmd) begin
                op    <= hdc_pkg::hdc_op_e'(wb_dat_w[`HDC_CMD_OP +: 2]);
                src_a <= wb_dat_w[`HDC_CMD_SRC_A +: `HDC_VSEL_W];
                src_b <= wb_dat_w[`HDC_CMD_SRC_B +: `HDC_VSEL_W];
                dst   <= wb_dat_w[`HDC_CMD_DST +: `HDC_VSEL_W];
                shift <= wb_dat_w[`HDC_CMD_SHIFT +: `HDC_SHIFT_W];
            end
        end
    end

    // readback, start bit reads as 0
    always_comb begin
        cmd_rd = '0;
        cmd_rd[`HDC_CMD_OP +: 2]                = op;
        cmd_rd[`HDC_CMD_SRC_A +: `HDC_VSEL_W]   = src_a;
        cmd_rd[`HDC_CMD_SRC_B +: `HDC_VSEL_W]   = src_b;
        cmd_rd[`HDC_CMD_DST +: `HDC_VSEL_W]     = dst;
        cmd_rd[`HDC_CMD_SHIFT +: `HDC_SHIFT_W]  = shift;
    end

    // read mux, unmapped reads zero
    always_comb begin
        if (is_cmd) begin
            rdata = cmd_rd;
        end else if (is_status) begin
            rdata = {{(`HDC_WORD - 1){1'b0}}, busy};
        end else if (is_vec) begin
            rdata = rd_data;
        end else begin
            rdata = '0;
        end
    end

    // read data held for the ack cycle
    always_ff @(posedge clk) begin
        if (req && !wb_we) begin
            wb_dat_r <= rdata;
        end
    end

endmodule

// File: hdc_top.sv
`timescale 1ns/1ps
`include "hdc_params.svh"

module hdc_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  logic [`HDC_ADR_W-1:0]    wb_adr,
    input  logic [`HDC_WORD-1:0]     wb_dat_w,
    output logic [`HDC_WORD-1:0]     wb_dat_r,
    output logic                     wb_ack
);

    // ------------------------------
    // command path, slave to engine
    // ------------------------------
    logic                     busy;
    logic                     start;
    hdc_pkg::hdc_op_e         op;
    logic [`HDC_VSEL_W-1:0]   src_a;
    logic [`HDC_VSEL_W-1:0]   src_b;
    logic [`HDC_VSEL_W-1:0]   dst;
    logic [`HDC_SHIFT_W-1:0]  shift;

    // ------------------------------
    // bank ports
    // ------------------------------
    // word access from the bus
    logic                     wr_en;
    logic [`HDC_VSEL_W-1:0]   wr_vec;
    logic [`HDC_WSEL_W-1:0]   wr_word;
    logic [`HDC_WORD-1:0]     wr_data;
    logic [`HDC_VSEL_W-1:0]   rd_vec;
    logic [`HDC_WSEL_W-1:0]   rd_word;
    logic [`HDC_WORD-1:0]     rd_data;
    // full-vector access from the engine
    logic [`HDC_VSEL_W-1:0]   sel_a;
    logic [`HDC_VSEL_W-1:0]   sel_b;
    logic [`HDC_DIM-1:0]      vec_a;
    logic [`HDC_DIM-1:0]      vec_b;
    logic                     res_en;
    logic [`HDC_VSEL_W-1:0]   res_vec;
    logic [`HDC_DIM-1:0]      res_data;

    hdc_wb_regs u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .busy     (busy),
        .start    (start),
        .op       (op),
        .src_a    (src_a),
        .src_b    (src_b),
        .dst      (dst),
        .shift    (shift),
        .wr_en    (wr_en),
        .wr_vec   (wr_vec),
        .wr_word  (wr_word),
        .wr_data  (wr_data),
        .rd_vec   (rd_vec),
        .rd_word  (rd_word),
        .rd_data  (rd_data)
    );

    hdc_vector_bank u_bank (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .wr_vec   (wr_vec),
        .wr_word  (wr_word),
        .wr_data  (wr_data),
        .rd_vec   (rd_vec),
        .rd_word  (rd_word),
        .rd_data  (rd_data),
        .sel_a    (sel_a),
        .sel_b    (sel_b),
        .vec_a    (vec_a),
        .vec_b    (vec_b),
        .res_en   (res_en),
        .res_vec  (res_vec),
        .res_data (res_data)
    );

    hdc_engine u_engine (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .op       (op),
        .src_a    (src_a),
        .src_b    (src_b),
        .dst      (dst),
        .shift    (shift),
        .busy     (busy),
        .sel_a    (sel_a),
        .sel_b    (sel_b),
        .vec_a    (vec_a),
        .vec_b    (vec_b),
        .res_en   (res_en),
        .res_vec  (res_vec),
        .res_data (res_data)
    );

endmodule

// File: hdc_tb_pkg.sv
`include "hdc_params.svh"

package hdc_tb_pkg;

    // bus signals, driven here and wired to the DUT in hdc_tb
    logic                    clk;
    logic                    cyc;
    logic                    stb;
    logic                    we;
    logic [`HDC_ADR_W-1:0]   adr;
    logic [`HDC_WORD-1:0]    dat_w;
    logic [`HDC_WORD-1:0]    dat_r;
    logic                    ack;

    // random preload source
    int seed = 32'h4184_6779;

    // expected bank contents
    logic [`HDC_DIM-1:0] model [`HDC_NVEC];

    // ------------------------------
    // test table
    // ------------------------------
    typedef struct packed {
        hdc_pkg::hdc_op_e        op;
        logic [`HDC_VSEL_W-1:0]  src_a;
        logic [`HDC_VSEL_W-1:0]  src_b;
        logic [`HDC_VSEL_W-1:0]  dst;
        logic [`HDC_SHIFT_W-1:0] shift;
        // 1 = random preload, 0 = address pattern
        logic                    rnd;
    } test_t;

    localparam int NTESTS = 8;

    localparam test_t TESTS [NTESTS] = '{
        '{hdc_pkg::OP_PERMUTE,      2'd0, 2'd1, 2'd1, 8'd0,   1'b1},
        '{hdc_pkg::OP_PERMUTE,      2'd1, 2'd2, 2'd2, 8'd1,   1'b1},
        '{hdc_pkg::OP_PERMUTE,      2'd2, 2'd3, 2'd3, 8'd37,  1'b0},
        '{hdc_pkg::OP_PERMUTE,      2'd3, 2'd1, 2'd0, 8'd128, 1'b1},
        // result lands on its own source
        '{hdc_pkg::OP_PERMUTE,      2'd0, 2'd2, 2'd0, 8'd255, 1'b1},
        // shift field must be ignored here
        '{hdc_pkg::OP_BIND,         2'd1, 2'd2, 2'd3, 8'd9,   1'b1},
        '{hdc_pkg::OP_PERMUTE_BIND, 2'd3, 2'd0, 2'd3, 8'd200, 1'b0},
        '{hdc_pkg::OP_NOP,          2'd0, 2'd1, 2'd2, 8'd5,   1'b1}
    };

    // ------------------------------
    // wishbone master, called at edge + 1 ns
    // ------------------------------
    task automatic write_word(input logic [`HDC_ADR_W-1:0] a, input logic [`HDC_WORD-1:0] d);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = 1'b1;
        adr   = a;
        dat_w = d;
        do begin
            @(posedge clk);
            #1;
        end while (!ack);
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
        // stb low for one edge before the next request
        @(posedge clk);
        #1;
    endtask

    task automatic read_word(input logic [`HDC_ADR_W-1:0] a, output logic [`HDC_WORD-1:0] d);
        cyc = 1'b1;
        stb = 1'b1;
        we  = 1'b0;
        adr = a;
        do begin
            @(posedge clk);
            #1;
        end while (!ack);
        // data valid with ack
        d   = dat_r;
        cyc = 1'b0;
        stb = 1'b0;
        @(posedge clk);
        #1;
    endtask

    // status bit 0 is busy
    task automatic poll_idle();
        logic [`HDC_WORD-1:0] st;
        do begin
            read_word(`HDC_ADR_STATUS, st);
        end while (st[0]);
    endtask

    // ------------------------------
    // address and command helpers
    // ------------------------------
    function automatic logic [`HDC_ADR_W-1:0] vec_addr(input int v, input int w);
        return `HDC_ADR_VEC_BASE + `HDC_ADR_W'(v * 32 + w * 4);
    endfunction

    function automatic logic [`HDC_WORD-1:0] make_cmd(input hdc_pkg::hdc_op_e op,
                                                      input logic [1:0] a,
                                                      input logic [1:0] b,
                                                      input logic [1:0] d,
                                                      input logic [7:0] sh,
                                                      input logic go);
        logic [`HDC_WORD-1:0] c;
        c = '0;
        c[`HDC_CMD_START]          = go;
        c[`HDC_CMD_OP +: 2]        = op;
        c[`HDC_CMD_SRC_A +: 2]     = a;
        c[`HDC_CMD_SRC_B +: 2]     = b;
        c[`HDC_CMD_DST +: 2]       = d;
        c[`HDC_CMD_SHIFT +: 8]     = sh;
        return c;
    endfunction

    // fixed fill, every address bit shows up
    function automatic logic [`HDC_WORD-1:0] fill_pattern(input logic [`HDC_ADR_W-1:0] a);
        return {8'h5a, a, ~a};
    endfunction

    // ------------------------------
    // reference model
    // ------------------------------
    function automatic void clear_model();
        for (int v = 0; v < `HDC_NVEC; v++) begin
            model[v] = '0;
        end
    endfunction

    // result bit i takes source bit (i + sh) mod dim
    function automatic logic [`HDC_DIM-1:0] rotate_bits(input logic [`HDC_DIM-1:0] src,
                                                        input int sh);
        logic [`HDC_DIM-1:0] r;
        for (int i = 0; i < `HDC_DIM; i++) begin
            r[i] = src[(i + sh) % `HDC_DIM];
        end
        return r;
    endfunction

    function automatic void apply_model(input test_t t);
        logic [`HDC_DIM-1:0] r;
        if (t.op != hdc_pkg::OP_NOP) begin
            r = model[t.src_a];
            if (t.op == hdc_pkg::OP_PERMUTE || t.op == hdc_pkg::OP_PERMUTE_BIND) begin
                r = rotate_bits(r, int'(t.shift));
            end
            if (t.op == hdc_pkg::OP_BIND || t.op == hdc_pkg::OP_PERMUTE_BIND) begin
                r = r ^ model[t.src_b];
            end
            model[t.dst] = r;
        end
    endfunction

    // loads one vector over the bus and mirrors it
    task automatic preload_vector(input int v, input logic rnd);
        logic [`HDC_WORD-1:0] d;
        for (int w = 0; w < `HDC_WPV; w++) begin
            if (rnd) begin
                d = $random(seed);
            end else begin
                d = fill_pattern(vec_addr(v, w));
            end
            write_word(vec_addr(v, w), d);
            model[v][w * `HDC_WORD +: `HDC_WORD] = d;
        end
    endtask

endpackage

// File: hdc_tb.sv
`timescale 1ns/1ps
`include "hdc_params.svh"

module hdc_tb;

    // per entry: preload, command, polls and readback, plus margin
    localparam int MAX_CYCLES = hdc_tb_pkg::NTESTS * (16 * 4 + 40) + 2000;

    logic                  rst_n;
    logic [`HDC_WORD-1:0]  wb_dat_r;
    logic                  wb_ack;
    int                    cycles = 0;

    hdc_top i_dut (
        .clk      (hdc_tb_pkg::clk),
        .rst_n    (rst_n),
        .wb_cyc   (hdc_tb_pkg::cyc),
        .wb_stb   (hdc_tb_pkg::stb),
        .wb_we    (hdc_tb_pkg::we),
        .wb_adr   (hdc_tb_pkg::adr),
        .wb_dat_w (hdc_tb_pkg::dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    // slave outputs back to the bus tasks
    always_comb begin
        hdc_tb_pkg::dat_r = wb_dat_r;
        hdc_tb_pkg::ack   = wb_ack;
    end

    // 10 ns clock
    initial begin
        hdc_tb_pkg::clk = 1'b0;
        forever begin
            #5;
            hdc_tb_pkg::clk = ~hdc_tb_pkg::clk;
        end
    end

    // ------------------------------
    // run limit
    // ------------------------------
    always @(posedge hdc_tb_pkg::clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: DUT did not finish within %0d cycles", MAX_CYCLES);
            $display("ERRORS FOUND");
            $fatal(1, "run aborted on timeout");
        end
    end

    task automatic check_value(input string name, input logic [`HDC_WORD-1:0] got,
                               input logic [`HDC_WORD-1:0] exp);
        assert (got === exp) else begin
            $display("ERR %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "value mismatch");
        end
    endtask

    // every word of every vector against the model
    task automatic check_bank();
        logic [`HDC_WORD-1:0] d;
        for (int v = 0; v < `HDC_NVEC; v++) begin
            for (int w = 0; w < `HDC_WPV; w++) begin
                hdc_tb_pkg::read_word(hdc_tb_pkg::vec_addr(v, w), d);
                check_value($sformatf("vec%0d word%0d", v, w), d,
                            hdc_tb_pkg::model[v][w * `HDC_WORD +: `HDC_WORD]);
            end
        end
    endtask

    initial begin
        hdc_tb_pkg::test_t     t;
        logic [`HDC_WORD-1:0]  rd;
        logic [`HDC_WORD-1:0]  cmd;
        logic [1:0]            blk;
        logic [`HDC_ADR_W-1:0] holes [4];
        holes = '{12'h008, 12'h0fc, 12'h180, 12'hffc};
        hdc_tb_pkg::cyc   = 1'b0;
        hdc_tb_pkg::stb   = 1'b0;
        hdc_tb_pkg::we    = 1'b0;
        hdc_tb_pkg::adr   = '0;
        hdc_tb_pkg::dat_w = '0;
        rst_n = 1'b0;
        repeat (5) @(posedge hdc_tb_pkg::clk);
        #1;
        rst_n = 1'b1;
        hdc_tb_pkg::clear_model();

        // ------------------------------
        // reset state and plain readback
        // ------------------------------
        check_bank();
        hdc_tb_pkg::read_word(`HDC_ADR_STATUS, rd);
        check_value("status", rd, 32'h0);
        hdc_tb_pkg::read_word(`HDC_ADR_CMD, rd);
        check_value("cmd", rd, 32'h0);
        hdc_tb_pkg::write_word(hdc_tb_pkg::vec_addr(2, 5), 32'hc0de_1234);
        hdc_tb_pkg::model[2][5 * `HDC_WORD +: `HDC_WORD] = 32'hc0de_1234;
        hdc_tb_pkg::read_word(hdc_tb_pkg::vec_addr(2, 5), rd);
        check_value("vec2 word5", rd, 32'hc0de_1234);

        // ------------------------------
        // table loop
        // ------------------------------
        for (int i = 0; i < hdc_tb_pkg::NTESTS; i++) begin
            t = hdc_tb_pkg::TESTS[i];
            hdc_tb_pkg::preload_vector(int'(t.src_a), t.rnd);
            hdc_tb_pkg::preload_vector(int'(t.src_b), t.rnd);
            cmd = hdc_tb_pkg::make_cmd(t.op, t.src_a, t.src_b, t.dst, t.shift, 1'b1);
            hdc_tb_pkg::write_word(`HDC_ADR_CMD, cmd);
            hdc_tb_pkg::read_word(`HDC_ADR_STATUS, rd);
            check_value("status busy", rd, 32'h1);
            // bank frozen while running
            blk = t.dst + 2'd1;
            hdc_tb_pkg::write_word(hdc_tb_pkg::vec_addr(blk, i),
                                   ~hdc_tb_pkg::model[blk][i * `HDC_WORD +: `HDC_WORD]);
            // second start, must be dropped by the engine
            cmd = hdc_tb_pkg::make_cmd(hdc_pkg::OP_PERMUTE, t.src_a, t.src_b, blk, 8'd3, 1'b1);
            hdc_tb_pkg::write_word(`HDC_ADR_CMD, cmd);
            hdc_tb_pkg::poll_idle();
            hdc_tb_pkg::read_word(`HDC_ADR_STATUS, rd);
            check_value("status idle", rd, 32'h0);
            hdc_tb_pkg::apply_model(t);
            check_bank();
        end

        // command readback drops the start bit
        cmd = hdc_tb_pkg::make_cmd(hdc_pkg::OP_NOP, 2'd1, 2'd2, 2'd3, 8'ha5, 1'b1);
        hdc_tb_pkg::write_word(`HDC_ADR_CMD, cmd);
        hdc_tb_pkg::poll_idle();
        hdc_tb_pkg::read_word(`HDC_ADR_CMD, rd);
        check_value("cmd", rd, cmd & ~32'h1);
        // holes in the map read zero
        for (int k = 0; k < 4; k++) begin
            hdc_tb_pkg::read_word(holes[k], rd);
            check_value($sformatf("unmapped 0x%03h", holes[k]), rd, 32'h0);
        end
        check_bank();

        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: sim.f
+incdir+.
hdc_pkg.sv
hdc_permute.sv
hdc_vector_bank.sv
hdc_engine.sv
hdc_wb_regs.sv
hdc_top.sv
hdc_tb_pkg.sv
hdc_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= hdc_tb
FLIST     ?= sim.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
